/* compile.f */
+incdir+.
mbist_types_pkg.sv
mbist_march_pkg.sv
mbist_fsm.sv
mbist_addr_gen.sv
mbist_march_seq.sv
mbist_pat_sel.sv
mbist_data_cmp.sv
mbist_mem_mux.sv
mbist_top.sv
tb_mbist_top.sv

/* mbist_addr_gen.sv */
`timescale 1ns/1ps
// Up/down test address counter that reloads per March element and flags the range end
`include "mbist_macros.svh"

module mbist_addr_gen (
        input  logic                        wb_clk_i,
        input  logic                        reset_i,
        input  logic                        start_i,
        input  logic                        run_elem_i,
        input  logic                        run_addr_i,
        input  logic                        updown_i,       // 1 counts up
        output mbist_types_pkg::bist_addr_t bist_addr_o,
        output logic                        last_addr_o
);
        import mbist_types_pkg::*;

        localparam bist_addr_t ADDR_FIRST = bist_addr_t'(`MBIST_ADDR_START);
        localparam bist_addr_t ADDR_LAST  = bist_addr_t'(`MBIST_ADDR_END);

        logic dir_up_q;         // Direction of the running element

        always_ff @(posedge wb_clk_i) begin
                if (reset_i) begin
                        bist_addr_o <= ADDR_FIRST;
                        dir_up_q    <= 1'b1;
                end else if (start_i || run_elem_i) begin
                        bist_addr_o <= updown_i ? ADDR_FIRST : ADDR_LAST;
                        dir_up_q    <= updown_i;
                end else if (run_addr_i) begin
                        bist_addr_o <= dir_up_q ? bist_addr_o + 1'b1 : bist_addr_o - 1'b1;
                end
        end

        assign last_addr_o = (bist_addr_o == (dir_up_q ? ADDR_LAST : ADDR_FIRST));

endmodule

/* mbist_data_cmp.sv */
`timescale 1ns/1ps
// Read data checker that keeps the sticky error, saturating count and first failing address
module mbist_data_cmp (
        input  logic                        wb_clk_i,
        input  logic                        reset_i,
        input  logic                        start_i,        // Clears the results
        input  logic                        cmp_phase_i,
        input  logic                        op_read_i,
        input  mbist_types_pkg::bist_data_t exp_data_i,
        input  mbist_types_pkg::bist_data_t rd_data_i,
        input  mbist_types_pkg::bist_addr_t addr_i,
        output logic                        bist_error_o,
        output mbist_types_pkg::err_cnt_t   bist_error_cnt_o,
        output mbist_types_pkg::bist_addr_t bist_error_addr_o
);
        logic mismatch;

        assign mismatch = cmp_phase_i && op_read_i && (rd_data_i != exp_data_i);

        always_ff @(posedge wb_clk_i) begin
                if (reset_i || start_i) begin
                        bist_error_o      <= 1'b0;
                        bist_error_cnt_o  <= '0;
                        bist_error_addr_o <= '0;
                end else if (mismatch) begin
                        bist_error_o <= 1'b1;
                        if (!(&bist_error_cnt_o)) begin
                                bist_error_cnt_o <= bist_error_cnt_o + 1'b1;
                        end
                        if (!bist_error_o) begin
                                bist_error_addr_o <= addr_i;    // First failure only
                        end
                end
        end

        // Count only moves down when a new run clears it
        a_cnt_mono: assert property (@(posedge wb_clk_i) disable iff (reset_i)
                !start_i |=> bist_error_cnt_o >= $past(bist_error_cnt_o));

endmodule

/* mbist_fsm.sv */
`timescale 1ns/1ps
// MBIST main control FSM with the run/done handshake, phase strobes and loop advance
module mbist_fsm (
        input  logic wb_clk_i,
        input  logic reset_i,
        input  logic bist_en_i,
        input  logic bist_run_i,        // Four-phase request
        input  logic last_op_i,
        input  logic last_addr_i,
        input  logic last_elem_i,
        input  logic last_pat_i,
        output logic bist_done_o,       // Four-phase acknowledge
        output logic cmd_phase_o,
        output logic cmp_phase_o,
        output logic run_op_o,
        output logic run_addr_o,
        output logic run_elem_o,
        output logic run_pat_o,
        output logic start_o
);
        typedef enum logic [2:0] {
                ST_IDLE, ST_CMD, ST_WAIT, ST_CMP, ST_DRAIN, ST_DONE
        } state_t;

        state_t state_q;
        state_t state_nxt;
        logic   all_last;
        logic   cmp_st;

        assign all_last = last_op_i && last_addr_i && last_elem_i && last_pat_i;
        assign cmp_st   = (state_q == ST_CMP);

        always_ff @(posedge wb_clk_i) begin
                if (reset_i) begin
                        state_q <= ST_IDLE;
                end else begin
                        state_q <= state_nxt;
                end
        end

        always_comb begin
                state_nxt = state_q;
                case (state_q)
                        ST_IDLE:  if (bist_en_i && bist_run_i) state_nxt = ST_CMD;
                        ST_CMD:   state_nxt = ST_WAIT;      // Mux registers the command
                        ST_WAIT:  state_nxt = ST_CMP;       // SRAM samples at the end
                        ST_CMP:   state_nxt = all_last ? ST_DRAIN : ST_CMD;
                        ST_DRAIN: state_nxt = ST_DONE;      // Last compare lands in the results
                        ST_DONE:  if (!bist_run_i) state_nxt = ST_IDLE;
                        default:  state_nxt = ST_IDLE;
                endcase
        end

        assign start_o     = (state_q == ST_IDLE) && bist_en_i && bist_run_i;
        assign cmd_phase_o = (state_q == ST_CMD);
        assign cmp_phase_o = cmp_st;
        assign bist_done_o = (state_q == ST_DONE);

        //--------------------------------------------------
        // Advance strobes, inner levels wrap with the carry
        //--------------------------------------------------
        assign run_op_o   = cmp_st && !all_last;
        assign run_addr_o = cmp_st && !all_last && last_op_i;
        assign run_elem_o = cmp_st && !all_last && last_op_i && last_addr_i;
        assign run_pat_o  = run_elem_o && last_elem_i;

        // Acknowledge holds for as long as the request does
        a_done_hold: assert property (@(posedge wb_clk_i) disable iff (reset_i)
                bist_done_o && bist_run_i |=> bist_done_o);

endmodule

/* mbist_macros.svh */
// Sizing and test address range of the MBIST controller, included by the packages and RTL
`ifndef MBIST_MACROS_SVH
`define MBIST_MACROS_SVH

`define MBIST_ADDR_WD     5     // SRAM depth of 32 words
`define MBIST_DATA_WD     32
`define MBIST_ADDR_START  0     // First tested address
`define MBIST_ADDR_END    31    // Last tested address
`define MBIST_ERR_CNT_WD  4     // Count saturates at 15
`define MBIST_NUM_PAT     4     // Data backgrounds
`define MBIST_NUM_ELEM    6     // March C- elements

`endif

/* mbist_march_pkg.sv */
// March C- element table and data background table for the sequencer and pattern selector
`include "mbist_macros.svh"

package mbist_march_pkg;

        // Element word {two_op, up, rd1, inv1, rd0, inv0}
        typedef logic [5:0] march_elem_t;

        localparam int ELEM_TWO_OP = 5;
        localparam int ELEM_UP     = 4;

        // Op field is {rd, inv}, op 0 in bits 1:0 and op 1 in bits 3:2
        localparam march_elem_t MARCH_ELEM_TABLE [`MBIST_NUM_ELEM] = '{
                6'b0_1_00_00,   // Any: w0
                6'b1_1_01_10,   // Up: r0 w1
                6'b1_1_00_11,   // Up: r1 w0
                6'b1_0_01_10,   // Down: r0 w1
                6'b1_0_00_11,   // Down: r1 w0
                6'b0_1_00_10    // Any: r0
        };

        // "1" in March notation is the inverted background
        localparam mbist_types_pkg::bist_data_t PAT_TABLE [`MBIST_NUM_PAT] = '{
                32'h0000_0000,
                32'h5555_5555,
                32'h3333_3333,
                32'h0F0F_0F0F
        };

endpackage

/* mbist_march_seq.sv */
`timescale 1ns/1ps
// March C- sequencer that steps element and operation and decodes the SRAM command
`include "mbist_macros.svh"

module mbist_march_seq (
        input  logic wb_clk_i,
        input  logic reset_i,
        input  logic start_i,
        input  logic cmd_phase_i,
        input  logic run_op_i,
        input  logic run_elem_i,
        input  logic run_pat_i,
        output logic op_read_o,
        output logic op_invert_o,
        output logic op_updown_o,
        output logic last_op_o,
        output logic last_elem_o,
        output logic bist_rd_o,
        output logic bist_wr_o
);
        import mbist_march_pkg::*;

        localparam int EW = $clog2(`MBIST_NUM_ELEM);

        logic [EW-1:0]  elem_q;
        logic [EW-1:0]  elem_nxt;
        logic           op_q;
        logic           op_nxt;
        march_elem_t    entry;
        logic [1:0]     op_field;       // {rd, inv}

        assign entry    = MARCH_ELEM_TABLE[elem_q];
        assign op_field = op_q ? entry[3:2] : entry[1:0];

        assign op_read_o   = op_field[1];
        assign op_invert_o = op_field[0];
        assign last_op_o   = op_q || !entry[ELEM_TWO_OP];
        assign last_elem_o = (elem_q == EW'(`MBIST_NUM_ELEM - 1));

        // Command only in the CMD phase, anything not a read is a write
        assign bist_rd_o = cmd_phase_i && op_read_o;
        assign bist_wr_o = cmd_phase_i && !op_read_o;

        always_comb begin
                elem_nxt = elem_q;
                op_nxt   = op_q;
                if (start_i || run_pat_i) begin
                        elem_nxt = '0;
                end else if (run_elem_i) begin
                        elem_nxt = elem_q + 1'b1;
                end
                if (start_i) begin
                        op_nxt = 1'b0;
                end else if (run_op_i) begin
                        op_nxt = !last_op_o;    // Wraps after the last op
                end
        end

        // Direction of the element in force after this cycle, so the
        // address counter loads the right end on a new element
        assign op_updown_o = MARCH_ELEM_TABLE[elem_nxt][ELEM_UP];

        always_ff @(posedge wb_clk_i) begin
                if (reset_i) begin
                        elem_q <= '0;
                        op_q   <= 1'b0;
                end else begin
                        elem_q <= elem_nxt;
                        op_q   <= op_nxt;
                end
        end

endmodule

/* mbist_mem_mux.sv */
`timescale 1ns/1ps
// Registered choice between MBIST and functional access toward the two SRAM ports
module mbist_mem_mux (
        input  logic                        wb_clk_i,
        input  logic                        reset_i,
        input  logic                        bist_en_i,
        input  logic                        bist_rd_i,
        input  logic                        bist_wr_i,
        input  mbist_types_pkg::bist_addr_t bist_addr_i,
        input  mbist_types_pkg::bist_data_t bist_wdata_i,
        input  logic                        func_cen_a_i,
        input  mbist_types_pkg::bist_addr_t func_addr_a_i,
        input  logic                        func_cen_b_i,
        input  logic                        func_web_b_i,
        input  mbist_types_pkg::bist_mask_t func_mask_b_i,
        input  mbist_types_pkg::bist_addr_t func_addr_b_i,
        input  mbist_types_pkg::bist_data_t func_din_b_i,
        input  mbist_types_pkg::bist_data_t mem_dout_a_i,
        output logic                        mem_cen_a_o,    // Active low
        output mbist_types_pkg::bist_addr_t mem_addr_a_o,
        output logic                        mem_cen_b_o,    // Active low
        output logic                        mem_web_b_o,    // Active low
        output mbist_types_pkg::bist_mask_t mem_mask_b_o,
        output mbist_types_pkg::bist_addr_t mem_addr_b_o,
        output mbist_types_pkg::bist_data_t mem_din_b_o,
        output mbist_types_pkg::bist_data_t func_dout_a_o
);
        //--------------------------------------------------
        // SRAM enables
        //--------------------------------------------------
        always_ff @(posedge wb_clk_i) begin
                if (reset_i) begin
                        mem_cen_a_o <= 1'b1;
                        mem_cen_b_o <= 1'b1;
                        mem_web_b_o <= 1'b1;
                end else if (bist_en_i) begin
                        mem_cen_a_o <= !bist_rd_i;
                        mem_cen_b_o <= !bist_wr_i;
                        mem_web_b_o <= !bist_wr_i;
                end else begin
                        mem_cen_a_o <= func_cen_a_i;
                        mem_cen_b_o <= func_cen_b_i;
                        mem_web_b_o <= func_web_b_i;
                end
        end

        // Address, mask and write data
        always_ff @(posedge wb_clk_i) begin
                if (bist_en_i) begin
                        mem_addr_a_o <= bist_addr_i;
                        mem_addr_b_o <= bist_addr_i;
                        mem_mask_b_o <= '1;             // Test writes whole words
                        mem_din_b_o  <= bist_wdata_i;
                end else begin
                        mem_addr_a_o <= func_addr_a_i;
                        mem_addr_b_o <= func_addr_b_i;
                        mem_mask_b_o <= func_mask_b_i;
                        mem_din_b_o  <= func_din_b_i;
                end
        end

        // Port A read data serves the functional side and the checker alike
        assign func_dout_a_o = mem_dout_a_i;

        a_rd_wr_excl: assert property (@(posedge wb_clk_i) disable iff (reset_i)
                !(bist_rd_i && bist_wr_i));

endmodule

/* mbist_pat_sel.sv */
`timescale 1ns/1ps
// Data background selector giving write and expected data, inverted per operation
`include "mbist_macros.svh"

module mbist_pat_sel (
        input  logic                        wb_clk_i,
        input  logic                        reset_i,
        input  logic                        start_i,
        input  logic                        run_pat_i,
        input  logic                        op_invert_i,
        output mbist_types_pkg::bist_data_t pat_data_o,
        output logic                        last_pat_o
);
        import mbist_march_pkg::*;

        localparam int PW = $clog2(`MBIST_NUM_PAT);

        logic [PW-1:0] pat_q;   // Background index

        always_ff @(posedge wb_clk_i) begin
                if (reset_i) begin
                        pat_q <= '0;
                end else if (start_i) begin
                        pat_q <= '0;
                end else if (run_pat_i) begin
                        pat_q <= pat_q + 1'b1;
                end
        end

        assign last_pat_o = (pat_q == PW'(`MBIST_NUM_PAT - 1));
        assign pat_data_o = PAT_TABLE[pat_q] ^ {`MBIST_DATA_WD{op_invert_i}};

endmodule

/* mbist_top.sv */
`timescale 1ns/1ps
// MBIST controller top that joins the control FSM, the March datapath and the SRAM port mux
module mbist_top (
        input  logic                        wb_clk_i,
        input  logic                        reset_i,
        // Test control and results
        input  logic                        bist_en_i,
        input  logic                        bist_run_i,
        output logic                        bist_done_o,
        output logic                        bist_error_o,
        output mbist_types_pkg::err_cnt_t   bist_error_cnt_o,
        output mbist_types_pkg::bist_addr_t bist_error_addr_o,
        // Functional port
        input  logic                        func_cen_a_i,
        input  mbist_types_pkg::bist_addr_t func_addr_a_i,
        input  logic                        func_cen_b_i,
        input  logic                        func_web_b_i,
        input  mbist_types_pkg::bist_mask_t func_mask_b_i,
        input  mbist_types_pkg::bist_addr_t func_addr_b_i,
        input  mbist_types_pkg::bist_data_t func_din_b_i,
        output mbist_types_pkg::bist_data_t func_dout_a_o,
        // SRAM, port A reads and port B writes
        output logic                        mem_cen_a_o,
        output mbist_types_pkg::bist_addr_t mem_addr_a_o,
        output logic                        mem_cen_b_o,
        output logic                        mem_web_b_o,
        output mbist_types_pkg::bist_mask_t mem_mask_b_o,
        output mbist_types_pkg::bist_addr_t mem_addr_b_o,
        output mbist_types_pkg::bist_data_t mem_din_b_o,
        input  mbist_types_pkg::bist_data_t mem_dout_a_i
);
        import mbist_types_pkg::*;

        logic           start;
        logic           cmd_phase, cmp_phase;
        logic           run_op, run_addr, run_elem, run_pat;    // Advance strobes
        logic           last_op, last_addr, last_elem, last_pat;
        logic           op_read, op_invert, op_updown;
        logic           bist_rd, bist_wr;
        bist_addr_t     bist_addr;
        bist_data_t     pat_data;       // Write data and expected read data

        mbist_fsm u_fsm (
                .wb_clk_i (wb_clk_i), .reset_i (reset_i),
                .bist_en_i (bist_en_i), .bist_run_i (bist_run_i),
                .last_op_i (last_op), .last_addr_i (last_addr),
                .last_elem_i (last_elem), .last_pat_i (last_pat),
                .bist_done_o (bist_done_o), .start_o (start),
                .cmd_phase_o (cmd_phase), .cmp_phase_o (cmp_phase),
                .run_op_o (run_op), .run_addr_o (run_addr),
                .run_elem_o (run_elem), .run_pat_o (run_pat)
        );

        mbist_addr_gen u_addr_gen (
                .wb_clk_i (wb_clk_i), .reset_i (reset_i), .start_i (start),
                .run_elem_i (run_elem), .run_addr_i (run_addr), .updown_i (op_updown),
                .bist_addr_o (bist_addr), .last_addr_o (last_addr)
        );

        mbist_march_seq u_march_seq (
                .wb_clk_i (wb_clk_i), .reset_i (reset_i), .start_i (start),
                .cmd_phase_i (cmd_phase), .run_op_i (run_op),
                .run_elem_i (run_elem), .run_pat_i (run_pat),
                .op_read_o (op_read), .op_invert_o (op_invert), .op_updown_o (op_updown),
                .last_op_o (last_op), .last_elem_o (last_elem),
                .bist_rd_o (bist_rd), .bist_wr_o (bist_wr)
        );

        mbist_pat_sel u_pat_sel (
                .wb_clk_i (wb_clk_i), .reset_i (reset_i), .start_i (start),
                .run_pat_i (run_pat), .op_invert_i (op_invert),
                .pat_data_o (pat_data), .last_pat_o (last_pat)
        );

        mbist_data_cmp u_data_cmp (
                .wb_clk_i (wb_clk_i), .reset_i (reset_i), .start_i (start),
                .cmp_phase_i (cmp_phase), .op_read_i (op_read),
                .exp_data_i (pat_data), .rd_data_i (func_dout_a_o), .addr_i (bist_addr),
                .bist_error_o (bist_error_o), .bist_error_cnt_o (bist_error_cnt_o),
                .bist_error_addr_o (bist_error_addr_o)
        );

        mbist_mem_mux u_mem_mux (
                .wb_clk_i (wb_clk_i), .reset_i (reset_i), .bist_en_i (bist_en_i),
                .bist_rd_i (bist_rd), .bist_wr_i (bist_wr),
                .bist_addr_i (bist_addr), .bist_wdata_i (pat_data),
                .func_cen_a_i (func_cen_a_i), .func_addr_a_i (func_addr_a_i),
                .func_cen_b_i (func_cen_b_i), .func_web_b_i (func_web_b_i),
                .func_mask_b_i (func_mask_b_i), .func_addr_b_i (func_addr_b_i),
                .func_din_b_i (func_din_b_i), .func_dout_a_o (func_dout_a_o),
                .mem_cen_a_o (mem_cen_a_o), .mem_addr_a_o (mem_addr_a_o),
                .mem_cen_b_o (mem_cen_b_o), .mem_web_b_o (mem_web_b_o),
                .mem_mask_b_o (mem_mask_b_o), .mem_addr_b_o (mem_addr_b_o),
                .mem_din_b_o (mem_din_b_o), .mem_dout_a_i (mem_dout_a_i)
        );

endmodule

/* mbist_types_pkg.sv */
// Datapath vector types shared by the MBIST modules and their ports
`include "mbist_macros.svh"

package mbist_types_pkg;

        typedef logic [`MBIST_ADDR_WD-1:0]    bist_addr_t;
        typedef logic [`MBIST_DATA_WD-1:0]    bist_data_t;
        typedef logic [`MBIST_DATA_WD/8-1:0]  bist_mask_t;  // One bit per data byte
        typedef logic [`MBIST_ERR_CNT_WD-1:0] err_cnt_t;

endpackage

/* run_sim.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
        --top-module tb_mbist_top -f compile.f

output=$(./obj_dir/Vtb_mbist_top)
echo "$output"

if echo "$output" | grep -qx "Simulation passed"; then
        exit 0
fi
exit 1

/* tb_mbist_top.sv */
`timescale 1ns/1ps
// Self-checking testbench for the MBIST top with an SRAM model, stuck-at injection and table runs
`include "mbist_macros.svh"

module tb_mbist_top;
        import mbist_types_pkg::*;

        localparam int NUM_ROWS  = 8;
        localparam int RUN_CYC   = 3842;        // Run request to done
        localparam int CYC_LIMIT = NUM_ROWS * 4000 + 500;
        localparam int NUM_FUNC  = 16;
        localparam int DEPTH     = 2 ** `MBIST_ADDR_WD;

        // Data backgrounds of the four passes
        localparam bist_data_t BG [4] = '{32'h0000_0000, 32'h5555_5555,
                                          32'h3333_3333, 32'h0F0F_0F0F};

        //--------------------------------------------------
        // Fault table with expected results filled in at start
        //--------------------------------------------------
        localparam logic       ROW_FAULT [NUM_ROWS] = '{1'b0, 1'b1, 1'b1, 1'b1,
                                                        1'b1, 1'b1, 1'b1, 1'b0};
        localparam bist_addr_t ROW_ADDR  [NUM_ROWS] = '{5'd0, 5'd0, 5'd31, 5'd7,
                                                        5'd18, 5'd31, 5'd0, 5'd0};
        localparam logic [4:0] ROW_BIT   [NUM_ROWS] = '{5'd0, 5'd0, 5'd0, 5'd5,
                                                        5'd5, 5'd2, 5'd31, 5'd0};
        localparam logic       ROW_VAL   [NUM_ROWS] = '{1'b0, 1'b0, 1'b1, 1'b0,
                                                        1'b1, 1'b0, 1'b1, 1'b0};

        logic           exp_err  [NUM_ROWS];
        err_cnt_t       exp_cnt  [NUM_ROWS];
        bist_addr_t     exp_addr [NUM_ROWS];

        logic           clk, reset, bist_en, bist_run;
        logic           bist_done, bist_error;
        err_cnt_t       bist_error_cnt;
        bist_addr_t     bist_error_addr;
        logic           func_cen_a, func_cen_b, func_web_b;
        bist_addr_t     func_addr_a, func_addr_b;
        bist_mask_t     func_mask_b;
        bist_data_t     func_din_b, func_dout;
        logic           mem_cen_a, mem_cen_b, mem_web_b;
        bist_addr_t     mem_addr_a, mem_addr_b;
        bist_mask_t     mem_mask_b;
        bist_data_t     mem_din_b;

        bist_data_t     sram [DEPTH];
        bist_data_t     sram_dout;
        logic           fault_en, fault_val;
        bist_addr_t     fault_addr;
        logic [4:0]     fault_bit;
        integer         seed;
        int             errors, checks, cycle_cnt;

        mbist_top i_dut (
                .wb_clk_i (clk), .reset_i (reset), .bist_en_i (bist_en), .bist_run_i (bist_run),
                .bist_done_o (bist_done), .bist_error_o (bist_error),
                .bist_error_cnt_o (bist_error_cnt), .bist_error_addr_o (bist_error_addr),
                .func_cen_a_i (func_cen_a), .func_addr_a_i (func_addr_a),
                .func_cen_b_i (func_cen_b), .func_web_b_i (func_web_b),
                .func_mask_b_i (func_mask_b), .func_addr_b_i (func_addr_b),
                .func_din_b_i (func_din_b), .func_dout_a_o (func_dout),
                .mem_cen_a_o (mem_cen_a), .mem_addr_a_o (mem_addr_a),
                .mem_cen_b_o (mem_cen_b), .mem_web_b_o (mem_web_b),
                .mem_mask_b_o (mem_mask_b), .mem_addr_b_o (mem_addr_b),
                .mem_din_b_o (mem_din_b), .mem_dout_a_i (sram_dout)
        );

        initial begin
                clk = 1'b0;
                forever #50 clk = ~clk;
        end

        // SRAM with one-cycle read and a stuck bit forced on the read path
        always @(posedge clk) begin
                if (!mem_cen_a) begin
                        sram_dout <= sram[mem_addr_a];
                        if (fault_en && mem_addr_a == fault_addr)
                                sram_dout[fault_bit] <= fault_val;
                end
                if (!mem_cen_b && !mem_web_b) begin
                        for (int b = 0; b < 4; b++) begin
                                if (mem_mask_b[b])
                                        sram[mem_addr_b][8*b +: 8] <= mem_din_b[8*b +: 8];
                        end
                end
        end

        // Stuck bit fails either the 3 r0 reads or the 2 r1 reads of each background
        function automatic int fault_count(input logic [4:0] bit_idx, input logic val);
                int n;
                n = 0;
                for (int p = 0; p < 4; p++) begin
                        if (BG[p][bit_idx] != val) n += 3;
                        else n += 2;
                end
                return (n > 15) ? 15 : n;
        endfunction

        task automatic check_value(input string name, input logic [31:0] got,
                                   input logic [31:0] exp);
                checks++;
                if (got !== exp) begin
                        errors++;
                        $display("MISMATCH %s got 0x%h expected 0x%h", name, got, exp);
                end
        endtask

        task automatic check_results(input int r);
                check_value("bist_error_o", 32'(bist_error), 32'(exp_err[r]));
                check_value("bist_error_cnt_o", 32'(bist_error_cnt), 32'(exp_cnt[r]));
                check_value("bist_error_addr_o", 32'(bist_error_addr), 32'(exp_addr[r]));
        endtask

        task automatic run_row(input int r);
                int cycles;
                @(negedge clk);
                fault_en   = ROW_FAULT[r];
                fault_addr = ROW_ADDR[r];
                fault_bit  = ROW_BIT[r];
                fault_val  = ROW_VAL[r];
                bist_run   = 1'b1;
                @(negedge clk);
                cycles = 1;
                check_value("bist_error_o", 32'(bist_error), 32'h0);      // Cleared by start
                check_value("bist_error_cnt_o", 32'(bist_error_cnt), 32'h0);
                check_value("bist_error_addr_o", 32'(bist_error_addr), 32'h0);
                while (!bist_done && cycles < RUN_CYC + 10) begin
                        @(negedge clk);
                        cycles++;
                end
                checks++;
                if (!bist_done) begin
                        errors++;
                        $display("Row %0d: bist_done_o never rose", r);
                end else if (cycles != RUN_CYC) begin
                        errors++;
                        $display("Row %0d: bist_done_o rose after %0d cycles, not %0d",
                                 r, cycles, RUN_CYC);
                end
                check_results(r);
                repeat (3) begin
                        @(negedge clk);
                        check_value("bist_done_o", 32'(bist_done), 32'h1);
                end
                bist_run = 1'b0;
                @(negedge clk);
                check_value("bist_done_o", 32'(bist_done), 32'h0);
                check_results(r);       // Still valid back in idle
        endtask

        task automatic func_test();
                bist_data_t model   [DEPTH];
                logic       written [DEPTH];
                bist_addr_t a;
                bist_data_t d;
                for (int i = 0; i < DEPTH; i++) written[i] = 1'b0;
                @(negedge clk);
                bist_en = 1'b0;
                for (int i = 0; i < NUM_FUNC; i++) begin
                        a = bist_addr_t'($random(seed));
                        d = $random(seed);
                        func_cen_b  = 1'b0;
                        func_web_b  = 1'b0;
                        func_addr_b = a;
                        func_din_b  = d;
                        model[a]    = d;
                        written[a]  = 1'b1;
                        @(negedge clk);
                end
                // Byte-masked write over the last word, bytes 0 and 2 only
                d           = $random(seed);
                func_mask_b = 4'b0101;
                func_din_b  = d;
                model[a]    = {model[a][31:24], d[23:16], model[a][15:8], d[7:0]};
                @(negedge clk);
                func_mask_b = '1;
                func_cen_b  = 1'b1;
                func_web_b  = 1'b1;
                @(negedge clk);
                for (int i = 0; i < DEPTH; i++) begin
                        if (written[i]) begin
                                func_cen_a  = 1'b0;
                                func_addr_a = bist_addr_t'(i);
                                @(negedge clk);
                                func_cen_a = 1'b1;
                                @(negedge clk);   // Mux register then SRAM read
                                check_value("func_dout_a_o", func_dout, model[i]);
                        end
                end
        endtask

        initial begin
                seed = 3;
                errors = 0;
                checks = 0;
                reset = 1'b1;
                bist_en = 1'b0;
                bist_run = 1'b0;
                func_cen_a = 1'b1;
                func_addr_a = '0;
                func_cen_b = 1'b1;
                func_web_b = 1'b1;
                func_mask_b = '1;
                func_addr_b = '0;
                func_din_b = '0;
                fault_en = 1'b0;
                fault_val = 1'b0;
                fault_addr = '0;
                fault_bit = '0;
                sram_dout = '0;
                for (int i = 0; i < DEPTH; i++) sram[i] = {4{3'b101, 5'(i)}};
                for (int r = 0; r < NUM_ROWS; r++) begin
                        exp_err[r]  = ROW_FAULT[r];
                        exp_cnt[r]  = ROW_FAULT[r] ?
                                      err_cnt_t'(fault_count(ROW_BIT[r], ROW_VAL[r])) : '0;
                        exp_addr[r] = ROW_FAULT[r] ? ROW_ADDR[r] : '0;
                end
                repeat (16) @(posedge clk);
                @(negedge clk);
                reset = 1'b0;
                bist_en = 1'b1;
                check_value("bist_done_o", 32'(bist_done), 32'h0);
                check_value("mem_cen_a_o", 32'(mem_cen_a), 32'h1);
                check_value("mem_cen_b_o", 32'(mem_cen_b), 32'h1);
                check_value("mem_web_b_o", 32'(mem_web_b), 32'h1);
                for (int r = 0; r < NUM_ROWS; r++) run_row(r);
                fault_en = 1'b0;
                func_test();
                $display("Checks: %0d, errors: %0d", checks, errors);
                if (errors == 0)
                        $display("Simulation passed");
                else
                        $display("Simulation failed");
                $finish;
        end

        // Watchdog
        initial begin
                cycle_cnt = 0;
                while (cycle_cnt < CYC_LIMIT) begin
                        @(posedge clk);
                        cycle_cnt++;
                end
                $display("Timeout: test did not end within %0d cycles", CYC_LIMIT);
                $display("Simulation failed");
                $finish;
        end

endmodule
